// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = fe_alu_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
FAIL_MSG  = Errors found

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(SIM) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/fe_alu_cases.txt
// Columns, all hex: op tag a b expected_value expected_err. Op 0 add, 1 sub, 2 and 3 reserved.
// One case per line. A line with op ee ends the list.
// Addition, including carries out of the low 128-bit half.
0 1 5 7 c 0
0 2 0 0 0 0
0 3 ffffffffffffffff_ffffffffffffffff 1 1_0000000000000000_0000000000000000 0
0 4 ffffffffffffffff_ffffffffffffffff ffffffffffffffff_ffffffffffffffff 1_ffffffffffffffff_fffffffffffffffe 0
0 5 100_0000000000000000_0000000000000000_0000000000000000 100_0000000000000000_0000000000000000_0000000000000000 200_0000000000000000_0000000000000000_0000000000000000 0
// Sums with bits at 255 and above fold back by 19.
0 6 4000000000000000_0000000000000000_0000000000000000_0000000000000000 4000000000000000_0000000000000000_0000000000000000_0000000000000000 13 0
0 7 8000000000000000_0000000000000000_0000000000000000_0000000000000000 5 18 0
0 8 40_0000000000000000_0000000000000000_0000000000000000_0000000000000000 40_0000000000000000_0000000000000000_0000000000000000_0000000000000000 1300 0
0 9 1_0000000000000000_0000000000000000_0000000000000000_0000000000000003 8000000000000000_0000000000000000_0000000000000000_0000000000000002 3e 0
0 a 7fffffffffffffff_ffffffffffffffff_ffffffffffffffff_ffffffffffffffff 8000000000000000_0000000000000000_0000000000000000_0000000000000000 8000000000000000_0000000000000000_0000000000000000_0000000000000012 0
0 b 7fffffffffffffff_ffffffffffffffff_ffffffffffffffff_ffffffffffffffed 13 13 0
0 c ff_0000000000000000_0000000000000000 1_0000000000000000_0000000000000000 100_0000000000000000_0000000000000000 0
// Subtraction as a + 4p - b, with b above a and borrows between the halves.
1 d 64 10 54 0
1 e 10 64 7fffffffffffffff_ffffffffffffffff_ffffffffffffffff_ffffffffffffff99 0
1 f 5 5 7fffffffffffffff_ffffffffffffffff_ffffffffffffffff_ffffffffffffffed 0
1 0 1_0000000000000000_0000000000000000 ffffffffffffffff_ffffffffffffffff 7fffffffffffffff_ffffffffffffffff_ffffffffffffffff_ffffffffffffffee 0
1 1 100_0000000000000000_0000000000000000_0000000000000000 ffffffffffffffff_ffffffffffffffff ff_ffffffffffffffff_0000000000000000_0000000000000001 0
1 2 1_0000000000000000_0000000000000000_0000000000000000_0000000000000000 1_ffffffffffffffff_ffffffffffffffff_ffffffffffffffff_ffffffffffffffff 7fffffffffffffff_ffffffffffffffff_ffffffffffffffff_ffffffffffffffc8 0
1 3 1000 fb4 4c 0
1 4 1000 fb5 8000000000000000_0000000000000000_0000000000000000_0000000000000038 0
1 5 1111111111111110 123456789abcdef fedcba987654321 0
0 6 123456789abcdef fedcba987654321 1111111111111110 0
// Rejected commands come back with value zero and the error bit set.
2 7 5 7 0 1
3 8 ab cd 0 1
1 9 5 2_0000000000000000_0000000000000000_0000000000000000_0000000000000000 0 1
1 a 0 80_0000000000000000_0000000000000000_0000000000000000_0000000000000000 0 1
// The subtrahend bound applies to sub only, so this add is computed.
0 b 3 2_0000000000000000_0000000000000000_0000000000000000_0000000000000001 50 0
3 c 0 2_0000000000000000_0000000000000000_0000000000000000_0000000000000000 0 1
ee 0 0 0 0 0

// File: bench/fe_alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fe_alu_tb;

	import fe_pkg::*;

	localparam int LATENCY		= 5;	// Cycles from the strobe to the result pulse.
	localparam int RESET_CYCLES	= 16;
	localparam int MAX_CASES	= 64;
	localparam int CASE_WORDS	= 6;	// op, tag, a, b, expected value, expected error.
	localparam int RESULT_TIMEOUT	= 20;	// A result later than this counts as lost.
	localparam int DRAIN_TIMEOUT	= 100;
	localparam logic [7:0] LFSR_SEED = 8'd35;
	localparam fe_word_t END_MARK	= 264'hee;	// Op field value that ends the case list.

	// One outstanding result, queued when its command is driven.
	typedef struct packed {
		int		idx;	// Case number, counted from one.
		int		sent;	// Cycle count at the falling edge that drove the strobe.
		fe_op_e		op;
		fe_tag_t	tag;
		logic		err;
		fe_word_t	value;
	} expect_t;

	logic		clk = 1'b0;
	logic		reset;
	logic		cmd_valid;
	fe_cmd_t	cmd;
	logic		res_valid;
	fe_result_t	res;

	fe_word_t	case_mem [MAX_CASES*CASE_WORDS];
	expect_t	expect_q [$];

	int		cycle = 0;	// Rising edges seen so far.
	int		n_cases;
	int		cases_run;
	int		cases_failed;
	int		other_errors;	// Lost results, stray pulses and load problems.
	logic		case_bad;	// Set by any failed compare in the current case.
	logic [7:0]	lfsr;

	fe_alu_top uut (
		.clk		(clk),
		.reset		(reset),
		.cmd_valid	(cmd_valid),
		.cmd		(cmd),
		.res_valid	(res_valid),
		.res		(res)
	);

	always #5 clk = ~clk;	// 10 ns period.

	always @(posedge clk)
		cycle <= cycle + 1;

	// Fibonacci LFSR for x^8 + x^6 + x^5 + x^4 + 1, shifting left.
	function automatic logic [7:0] lfsr_next(input logic [7:0] state);
		logic fb;
		fb = state[7] ^ state[5] ^ state[4] ^ state[3];
		return {state[6:0], fb};
	endfunction

	// Each bit taken costs one LFSR step. The new bit becomes the next value bit.
	task automatic take_random_bits(input int count, output int value);
		int k;
		value = 0;
		for (k = 0; k < count; k++) begin
			lfsr = lfsr_next(lfsr);
			value = (value << 1) | int'(lfsr[0]);
		end
	endtask

	function automatic string op_name(input fe_op_e op);
		case (op)
			FE_OP_ADD:	return "add";
			FE_OP_SUB:	return "sub";
			default:	return "reserved";
		endcase
	endfunction

	task automatic check_value(input string name, input string field,
			input fe_word_t expected, input fe_word_t actual);
		if (actual !== expected) begin	// Also catches X or Z on the outputs.
			$display("Fail %s %s: expected %h, actual %h", name, field, expected, actual);
			case_bad = 1'b1;
		end
	endtask

	// Puts case i on the inputs and queues what should come back.
	task automatic drive_case(input int i);
		int		base;
		expect_t	e;
		base		= i * CASE_WORDS;
		cmd_valid	= 1'b1;
		cmd.op		= fe_op_e'(case_mem[base][1:0]);
		cmd.tag		= case_mem[base+1][3:0];
		cmd.a.raw	= case_mem[base+2];
		cmd.b.raw	= case_mem[base+3];
		e.idx		= i + 1;
		e.sent		= cycle;
		e.op		= cmd.op;
		e.tag		= cmd.tag;
		e.value		= case_mem[base+4];
		e.err		= case_mem[base+5][0];
		expect_q.push_back(e);
	endtask

	// Outputs come from registers, so they are settled at the falling edge.
	// An entry queued at this same edge is not outstanding yet.
	always @(negedge clk) begin : monitor
		expect_t	e;
		string		name;
		string		verdict;
		if (res_valid !== 1'b0) begin
			if (expect_q.size() == 0 || expect_q[0].sent == cycle) begin
				other_errors++;
				if (reset)
					$display("res_valid went high during reset at cycle %0d", cycle);
				else
					$display("res_valid pulsed at cycle %0d with no command outstanding",
						cycle);
			end else begin
				e = expect_q.pop_front();
				name = $sformatf("case_%0d", e.idx);
				case_bad = 1'b0;
				check_value(name, "tag", 264'(e.tag), 264'(res.tag));
				check_value(name, "err", 264'(e.err), 264'(res.err));
				check_value(name, "value", e.value, res.value);
				check_value(name, "latency", 264'(LATENCY), 264'(cycle - e.sent));
				cases_run++;
				if (case_bad) begin
					cases_failed++;
					verdict = "failed";
				end else begin
					verdict = "ok";
				end
				$display("%s %s tag %h: %s", name, op_name(e.op), e.tag, verdict);
			end
		end else if (expect_q.size() != 0 && cycle - expect_q[0].sent > RESULT_TIMEOUT) begin
			e = expect_q.pop_front();	// Give up on it so later results still line up.
			other_errors++;
			cases_run++;
			cases_failed++;
			$display("case_%0d timed out with no result within %0d cycles of its command",
				e.idx, RESULT_TIMEOUT);
		end
	end

	initial begin : stimulus
		int	i;
		int	gap;
		int	waited;
		reset		= 1'b1;
		cmd_valid	= 1'b0;
		cmd		= '0;
		lfsr		= LFSR_SEED;
		n_cases		= 0;
		cases_run	= 0;
		cases_failed	= 0;
		other_errors	= 0;
		case_bad	= 1'b0;

		$readmemh("bench/fe_alu_cases.txt", case_mem);
		while (n_cases < MAX_CASES && case_mem[n_cases*CASE_WORDS] != END_MARK)
			n_cases++;
		if (n_cases == 0) begin
			other_errors++;
			$display("No cases could be loaded from bench/fe_alu_cases.txt");
		end

		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		// Odd groups of four go back to back, the others get 0 to 3 idle cycles.
		for (i = 0; i < n_cases; i++) begin
			if ((i / 4) % 2 == 1)
				gap = 0;
			else
				take_random_bits(2, gap);
			repeat (gap) begin
				cmd_valid = 1'b0;
				@(negedge clk);
			end
			drive_case(i);
			@(negedge clk);
		end
		cmd_valid = 1'b0;

		waited = 0;
		while (expect_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (expect_q.size() != 0) begin
			other_errors++;
			$display("Timed out after %0d cycles with %0d results still outstanding",
				DRAIN_TIMEOUT, expect_q.size());
		end

		repeat (10) @(negedge clk);	// Quiet tail, any pulse here is a stray.

		$display("Summary: %0d cases loaded, %0d checked, %0d failed, %0d other errors",
			n_cases, cases_run, cases_failed, other_errors);
		if (n_cases > 0 && cases_run == n_cases && cases_failed == 0 && other_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/fe_add.sv
`timescale 1ns/1ps
`default_nettype none

module fe_add(
	input wire logic		clk,
	input wire logic		reset,
	input wire logic		en,
	input wire fe_pkg::fe_elem_u	a,
	input wire fe_pkg::fe_elem_u	b,
	output logic			out_valid,
	output fe_pkg::fe_word_t	out
);

	import fe_pkg::*;

	logic		en_ff;		// Stage one holds a valid sum pair.
	logic [128:0]	sum_low;	// Low half sum with its carry out in bit 128.
	logic [135:0]	sum_high;	// High half sum, still missing the low carry.

	// Control path. Only the valid bits are reset.
	always_ff @(posedge clk) begin
		if (reset) begin
			en_ff		<= 1'b0;
			out_valid	<= 1'b0;
		end else begin
			en_ff		<= en;
			out_valid	<= en_ff;
		end
	end

	// First stage adds both halves side by side.
	// This keeps the longest carry chain at 136 bits instead of 264.
	always_ff @(posedge clk) begin
		if (en) begin
			sum_low		<= {1'b0, a.half.lo} + {1'b0, b.half.lo};
			sum_high	<= a.half.hi + b.half.hi;
		end
		if (en_ff)
			out	<= {sum_high + 136'(sum_low[128]), sum_low[127:0]};	// Ripple the carry up.
	end

	// Each result follows its enable by two cycles and equals the full-width sum of the
	// operands seen with that enable, so a carry lost between the halves shows up here.
	assert property (@(posedge clk) disable iff (reset)
		out_valid |-> $past(en, 2) && out == fe_word_t'($past(a.raw, 2) + $past(b.raw, 2)));

endmodule

`default_nettype wire

// File: src/fe_alu_top.sv
`timescale 1ns/1ps
`default_nettype none

module fe_alu_top #(
	parameter int TAG_DEPTH = 5	// Must match the summed latency of control, unit and fold.
) (
	input wire logic		clk,
	input wire logic		reset,
	input wire logic		cmd_valid,
	input wire fe_pkg::fe_cmd_t	cmd,
	output logic			res_valid,
	output fe_pkg::fe_result_t	res
);

	import fe_pkg::*;

	logic		add_en;
	logic		sub_en;
	fe_elem_u	a_q;		// Operands shared by both units.
	fe_elem_u	b_q;

	logic		add_valid;
	fe_word_t	add_out;
	logic		sub_valid;
	fe_word_t	sub_out;

	logic		red_en;		// Whichever unit finished this cycle.
	fe_word_t	red_in;
	logic		red_valid;
	fe_word_t	red_out;

	fe_op_control #(
		.TAG_DEPTH(TAG_DEPTH)
	) control (
		.clk		(clk),
		.reset		(reset),
		.cmd_valid	(cmd_valid),
		.cmd		(cmd),
		.add_en		(add_en),
		.sub_en		(sub_en),
		.a_q		(a_q),
		.b_q		(b_q),
		.add_valid	(add_valid),
		.add_out	(add_out),
		.sub_valid	(sub_valid),
		.sub_out	(sub_out),
		.red_en		(red_en),
		.red_in		(red_in),
		.red_valid	(red_valid),
		.red_out	(red_out),
		.res_valid	(res_valid),
		.res		(res)
	);

	fe_add adder (
		.clk		(clk),
		.reset		(reset),
		.en		(add_en),
		.a		(a_q),
		.b		(b_q),
		.out_valid	(add_valid),
		.out		(add_out)
	);

	fe_sub subtractor (
		.clk		(clk),
		.reset		(reset),
		.en		(sub_en),
		.a		(a_q),
		.b		(b_q),
		.out_valid	(sub_valid),
		.out		(sub_out)
	);

	fe_reduce reducer (
		.clk		(clk),
		.reset		(reset),
		.en		(red_en),
		.in		(red_in),
		.out_valid	(red_valid),
		.out		(red_out)
	);

endmodule

`default_nettype wire

// File: src/fe_op_control.sv
`timescale 1ns/1ps
`default_nettype none

module fe_op_control #(
	parameter int TAG_DEPTH = 5	// Cycles from command strobe to result.
) (
	input wire logic		clk,
	input wire logic		reset,

	input wire logic		cmd_valid,
	input wire fe_pkg::fe_cmd_t	cmd,

	output logic			add_en,
	output logic			sub_en,
	output fe_pkg::fe_elem_u	a_q,
	output fe_pkg::fe_elem_u	b_q,

	input wire logic		add_valid,
	input wire fe_pkg::fe_word_t	add_out,
	input wire logic		sub_valid,
	input wire fe_pkg::fe_word_t	sub_out,

	output logic			red_en,
	output fe_pkg::fe_word_t	red_in,
	input wire logic		red_valid,
	input wire fe_pkg::fe_word_t	red_out,

	output logic			res_valid,
	output fe_pkg::fe_result_t	res
);

	import fe_pkg::*;

	// One entry per cycle of latency. Slots holding no command keep valid low.
	typedef struct packed {
		logic		valid;
		fe_tag_t	tag;
		logic		err;
	} tag_ent_t;

	tag_ent_t	tag_q [TAG_DEPTH];

	logic	op_known;	// Operation code is one we compute.
	logic	b_ok;		// Subtrahend fits below 2^257, so a + 4p - b stays non-negative.
	logic	cmd_err;	// Command is accepted but reported as rejected.

	always_comb begin
		case (cmd.op)
			FE_OP_ADD:	op_known = 1'b1;
			FE_OP_SUB:	op_known = 1'b1;
			FE_OP_RSV2,
			FE_OP_RSV3:	op_known = 1'b0;
			default:	op_known = 1'b0;
		endcase
	end

	assign b_ok	= (cmd.b.raw[263:FE_B_BOUND_LSB] == '0);
	assign cmd_err	= !op_known || (cmd.op == FE_OP_SUB && !b_ok);	// The bound only matters for sub.

	// Launch at most one unit per command. A rejected one launches nothing.
	always_ff @(posedge clk) begin
		if (reset) begin
			add_en	<= 1'b0;
			sub_en	<= 1'b0;
		end else begin
			add_en	<= cmd_valid && !cmd_err && cmd.op == FE_OP_ADD;
			sub_en	<= cmd_valid && !cmd_err && cmd.op == FE_OP_SUB;
		end
	end

	// Both units share the registered operands.
	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			a_q	<= cmd.a;
			b_q	<= cmd.b;
		end
	end

	// Tag pipeline. Each command enters on its strobe and reaches the tail together with its
	// reduced value.
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < TAG_DEPTH; i++)
				tag_q[i] <= '0;
		end else begin
			tag_q[0]	<= '{valid: cmd_valid, tag: cmd.tag, err: cmd_err};
			for (int i = 1; i < TAG_DEPTH; i++)
				tag_q[i] <= tag_q[i-1];
		end
	end

	// The two units never finish on the same cycle, so a simple select is enough.
	assign red_en	= add_valid || sub_valid;
	assign red_in	= add_valid ? add_out : sub_out;

	// The result pairs the tail entry with whatever the reducer presents now.
	assign res_valid	= tag_q[TAG_DEPTH-1].valid;
	assign res.tag		= tag_q[TAG_DEPTH-1].tag;
	assign res.err		= tag_q[TAG_DEPTH-1].err;
	assign res.value	= tag_q[TAG_DEPTH-1].err ? '0 : red_out;	// Rejected commands read zero.

	// Each command launches one unit and both have equal latency.
	// A collision would mean the launch logic is broken.
	assert property (@(posedge clk) disable iff (reset) !(add_valid && sub_valid));

	// The datapath and the tag pipeline must stay in lockstep.
	assert property (@(posedge clk) disable iff (reset)
		red_valid == (tag_q[TAG_DEPTH-1].valid && !tag_q[TAG_DEPTH-1].err));

endmodule

`default_nettype wire

// File: src/fe_pkg.sv
`default_nettype none

package fe_pkg;

	// Field elements modulo p = 2^255 - 19 travel in 264-bit words.
	// The spare bits above bit 255 hold carries until the fold removes them.
	typedef logic [263:0] fe_word_t;

	// The same word split for the two-stage carry chain in the adder and subtractor.
	typedef struct packed {
		logic [135:0]	hi;	// Upper 136 bits, including the carry headroom.
		logic [127:0]	lo;	// Lower 128 bits.
	} fe_split_t;

	// One element seen either as a raw word or as its two halves.
	typedef union packed {
		fe_word_t	raw;
		fe_split_t	half;
	} fe_elem_u;

	// Operation codes. The two upper codes are reserved, and the control module rejects them.
	typedef enum logic [1:0] {
		FE_OP_ADD	= 2'd0,
		FE_OP_SUB	= 2'd1,
		FE_OP_RSV2	= 2'd2,
		FE_OP_RSV3	= 2'd3
	} fe_op_e;

	typedef logic [3:0] fe_tag_t;	// Caller's tag, handed back with the result.

	typedef struct packed {
		fe_op_e		op;
		fe_tag_t	tag;
		fe_elem_u	a;
		fe_elem_u	b;	// Subtrahend for FE_OP_SUB.
	} fe_cmd_t;

	typedef struct packed {
		fe_tag_t	tag;
		fe_word_t	value;	// Zero when err is set.
		logic		err;	// Set for a rejected command.
	} fe_result_t;

	// Four times p, i.e. 2^257 - 76. It is added before subtracting so the difference stays positive.
	localparam fe_word_t FE_P4 = (264'd1 << 257) - 264'd76;
	localparam int FE_B_BOUND_LSB = 257;	// A subtrahend with any bit set here or above is rejected.
	localparam logic [4:0] FE_FOLD_MUL = 5'd19;	// 2^255 is congruent to 19 mod p.

endpackage

`default_nettype wire

// File: src/fe_reduce.sv
`timescale 1ns/1ps
`default_nettype none

module fe_reduce(
	input wire logic		clk,
	input wire logic		reset,
	input wire logic		en,
	input wire fe_pkg::fe_word_t	in,
	output logic			out_valid,
	output fe_pkg::fe_word_t	out
);

	import fe_pkg::*;

	logic		en_ff;		// Stage one holds a split word.
	logic [254:0]	low_q;		// Bits below 2^255, kept as they are.
	logic [13:0]	fold_q;		// Bits 263:255 times 19, at most 511 * 19 = 9709.

	always_ff @(posedge clk) begin
		if (reset) begin
			en_ff		<= 1'b0;
			out_valid	<= 1'b0;
		end else begin
			en_ff		<= en;
			out_valid	<= en_ff;
		end
	end

	// First stage.
	// Since 2^255 = 19 mod p, each unit above bit 254 is worth 19 units at the bottom.
	// The multiply is only nine bits by five, so it fits in one cycle beside the register.
	always_ff @(posedge clk) begin
		if (en) begin
			low_q	<= in[254:0];
			fold_q	<= in[263:255] * FE_FOLD_MUL;
		end
	end

	// Second stage.
	// The sum is at most (2^255 - 1) + 9709, so it fits in 256 bits.
	// It is congruent to the input but not always below p.
	always_ff @(posedge clk) begin
		if (en_ff)
			out	<= {8'd0, {1'b0, low_q} + 256'(fold_q)};
	end

	// Enable and valid are registered separately from the data.
	// An idle cycle therefore leaves out unchanged, and consumers look only at out_valid.

endmodule

`default_nettype wire

// File: src/fe_sub.sv
`timescale 1ns/1ps
`default_nettype none

module fe_sub(
	input wire logic		clk,
	input wire logic		reset,
	input wire logic		en,
	input wire fe_pkg::fe_elem_u	a,
	input wire fe_pkg::fe_elem_u	b,
	output logic			out_valid,
	output fe_pkg::fe_word_t	out
);

	import fe_pkg::*;

	// 4p split the same way as the operands.
	localparam fe_split_t P4_HALF = FE_P4;

	logic		en_ff;		// Stage one holds a valid difference pair.
	logic [129:0]	dif_low;	// Low half of a + 4p - b, two's complement with two extra bits.
	logic [135:0]	dif_high;	// High half of a + 4p - b before the low carry or borrow.
	logic [135:0]	low_adj;	// Sign-extended carry or borrow out of the low half.

	always_ff @(posedge clk) begin
		if (reset) begin
			en_ff		<= 1'b0;
			out_valid	<= 1'b0;
		end else begin
			en_ff		<= en;
			out_valid	<= en_ff;
		end
	end

	// The low half lands somewhere in -(2^128 - 1) .. 2^129 - 2.
	// Bits 129:128 therefore read as a signed carry of -1, 0 or +1.
	assign low_adj = {{134{dif_low[129]}}, dif_low[129:128]};

	always_ff @(posedge clk) begin
		if (en) begin
			dif_low		<= {2'b00, a.half.lo} + {2'b00, P4_HALF.lo} - {2'b00, b.half.lo};
			dif_high	<= a.half.hi + P4_HALF.hi - b.half.hi;
		end

		// Adding the carry may also take a borrow out of the high half.
		if (en_ff)
			out	<= {dif_high + low_adj, dif_low[127:0]};
	end

	// Since b stays below 2^257, a + 4p - b is a non-negative word congruent to a - b.
	// The control module rejects anything larger before it gets here.

endmodule

`default_nettype wire

// File: verilog.f
src/fe_pkg.sv
src/fe_add.sv
src/fe_sub.sv
src/fe_reduce.sv
src/fe_op_control.sv
src/fe_alu_top.sv
bench/fe_alu_tb.sv
